// ==== design/apu.sv ====
`default_nettype none

module apu
	import apu_isa_pkg::*;
	import apu_io_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire halt,
	output logic rdy,
	input wire code_wen,
	input wire byte_t code_wdata,
	input wire [8:0] code_waddr,	// byte address into code RAM
	output dram_req_t dram,
	input wire dram_strobe,
	input wire word_t dram_data_r,
	output byte_t covox,
	output logic covox_we,
	output logic [5:0] border,
	output logic border_we,
	input wire video_t video
);

	word_t instr;
	code_addr_t pc_next;		// fetch address
	word_t timer_wdata, timer_count;
	logic timer_we, timer_end;

	apu_code_ram i_code_ram (
		.clk(clk),
		.rst_n(rst_n),
		.wen(code_wen),
		.wdata(code_wdata),
		.waddr(code_waddr),
		.raddr(pc_next),
		.instr(instr)
	);

	apu_core i_core (
		.clk(clk),
		.rst_n(rst_n),
		.halt(halt),
		.instr(instr),
		.timer_count(timer_count),
		.timer_end(timer_end),
		.dram_strobe(dram_strobe),
		.dram_data_r(dram_data_r),
		.video(video),
		.pc_next(pc_next),
		.timer_wdata(timer_wdata),
		.timer_we(timer_we),
		.covox(covox),
		.covox_we(covox_we),
		.border(border),
		.border_we(border_we),
		.dram(dram),
		.rdy(rdy)
	);

	apu_timer i_timer (
		.clk(clk),
		.rst_n(rst_n),
		.wdata(timer_wdata),
		.we(timer_we),
		.count(timer_count),
		.cnt_end(timer_end)
	);

endmodule

`default_nettype wire

// ==== design/apu_alu.sv ====
`default_nettype none

module apu_alu
	import apu_isa_pkg::*;
(
	input wire opcode_e op,
	input wire byte_t a,			// destination register value
	input wire byte_t imm,
	input wire flags_t flags_in,
	output byte_t result,
	output flags_t flags_out,
	output logic wr				// class writes a register
);

	logic [8:0] sum;		// carry or borrow in bit 8

	always_comb
	begin
		sum = {1'b0, a};
		result = a;
		wr = 1'b1;
		flags_out = flags_in;
		case (op)
			ld_imm:
				result = imm;
			and_imm:
				result = a & imm;
			or_imm:
				result = a | imm;
			xor_imm:
				result = a ^ imm;
			add_imm:
			begin
				sum = {1'b0, a} + {1'b0, imm};
				result = sum[7:0];
				flags_out.c = sum[8];		// carry out
			end
			sub_imm:
			begin
				sum = {1'b0, a} - {1'b0, imm};
				result = sum[7:0];
				flags_out.c = sum[8];		// borrow, a < imm
			end
			default:
				wr = 1'b0;			// not an alu class
		endcase

		// z and n follow every register write of the alu
		if (wr)
		begin
			flags_out.z = (result == 8'h00);
			flags_out.n = result[7];
		end
	end

endmodule

`default_nettype wire

// ==== design/apu_code_ram.sv ====
`default_nettype none

module apu_code_ram
	import apu_isa_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire wen,				// one byte per strobe
	input wire byte_t wdata,
	input wire [8:0] waddr,		// byte address
	input wire code_addr_t raddr,
	output word_t instr
);

	word_t mem [256];
	byte_t lo_byte;		// even byte waits here for its pair
	logic word_we;

	// the odd byte completes the word
	assign word_we = wen && waddr[0];

	always_ff @(posedge clk)
	begin
		if (wen && !waddr[0])
			lo_byte <= wdata;
	end

	always_ff @(posedge clk)
	begin
		if (word_we)
			mem[waddr[8:1]] <= {wdata, lo_byte};
	end

	// registered read, instr belongs to last cycle's raddr
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			instr <= halt_hold_instr;	// core parks at 0 for one cycle out of reset
		else
			instr <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== design/apu_core.sv ====
`default_nettype none

module apu_core
	import apu_isa_pkg::*;
	import apu_io_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire halt,
	input wire word_t instr,
	input wire word_t timer_count,
	input wire timer_end,
	input wire dram_strobe,
	input wire word_t dram_data_r,
	input wire video_t video,
	output code_addr_t pc_next,
	output word_t timer_wdata,
	output logic timer_we,
	output byte_t covox,
	output logic covox_we,
	output logic [5:0] border,
	output logic border_we,
	output dram_req_t dram,
	output logic rdy
);

	instr_t ir;				// instruction executing now
	opcode_e op;
	byte_t regs [16];		// r14/r15 hold the pc
	flags_t flags;
	word_t pc, pc_nxt;
	reg_idx_t src;			// djnz counter register
	byte_t dst_val, djnz_val, port_in, alu_res;
	flags_t alu_flags;
	logic alu_wr, jcond, pin_val, port_wr, port_rd;
	word_t rel_jr, rel_djnz;
	logic [31:0] pins_in;
	port_idx_t port;
	byte_t timer_lo, addr0, addr1, wdata_lo, wdata_hi;
	logic [4:0] addr2;
	word_t dram_rdata;		// captured on dram_strobe
	logic req, rnw;
	logic [1:0] bsel;

	// halt input parks the core on the hold instruction
	assign ir = halt ? instr_t'(halt_hold_instr) : instr_t'(instr);
	assign op = ir.op;
	assign pc = {regs[pc_hi_reg], regs[pc_lo_reg]};
	assign src = ir.imm[3:0];
	assign port = ir.imm[3:0];
	assign dst_val = regs[ir.dst];
	assign djnz_val = regs[src] - 8'd1;
	assign rel_jr = {{8{ir.imm[7]}}, ir.imm};			// rel8 from imm
	assign rel_djnz = {{8{ir.dst[3]}}, ir.dst, ir.imm[7:4]};	// rel8 from instr[11:4]
	assign port_wr = (op == io_port) && ir.imm[7];		// out (port), dst
	assign port_rd = (op == io_port) && !ir.imm[7];	// in dst, (port)

	apu_alu i_alu (
		.op(op),
		.a(dst_val),
		.imm(ir.imm),
		.flags_in(flags),
		.result(alu_res),
		.flags_out(alu_flags),
		.wr(alu_wr)
	);

	always_comb
	begin
		case (cond_e'(ir.dst))
			always_c:		jcond = 1'b1;
			equal:			jcond = flags.z;
			less:			jcond = flags.c;
			nequal:			jcond = !flags.z;
			greater:		jcond = !flags.c && !flags.z;
			lessequal:		jcond = flags.c || flags.z;
			greaterequal:	jcond = !flags.c;
			negative:		jcond = flags.n;
			positive:		jcond = !flags.n;
			default:		jcond = 1'b0;	// never, plus signed and half carry codes
		endcase
	end

	always_comb
	begin
		pins_in = '0;
		pins_in[pin_timer_end] = timer_end;
		pins_in[pin_dram_strobe] = dram_strobe;
		pins_in[pin_hsync] = video.hsync;
		pins_in[pin_hblank] = video.hblank;
		pins_in[pin_vsync] = video.vsync;
		pins_in[pin_vblank] = video.vblank;
	end

	assign pin_val = pins_in[pin_idx_t'(ir.imm[4:0])];

	always_comb
	begin
		case (port)
			in_dram_lo:		port_in = dram_rdata[7:0];
			in_dram_hi:		port_in = dram_rdata[15:8];
			in_timer_lo:	port_in = timer_count[7:0];
			in_timer_hi:	port_in = timer_count[15:8];
			in_hcnt_lo:		port_in = video.hcnt[7:0];
			in_hcnt_hi:		port_in = {7'd0, video.hcnt[8]};
			in_vcnt_lo:		port_in = video.vcnt[7:0];
			in_vcnt_hi:		port_in = {7'd0, video.vcnt[8]};
			default:		port_in = '0;
		endcase
	end

	always_comb
	begin
		if (halt)
			pc_nxt = '0;		// restart point
		else
			case (op)
				wt_pin:		// stay here until pin == cond bit
					pc_nxt = (pin_val == ir.dst[3]) ? pc + 16'd1 : pc;
				jr:
					pc_nxt = jcond ? pc + rel_jr : pc + 16'd1;
				djnz:
					pc_nxt = (djnz_val != 8'h00) ? pc + rel_djnz : pc + 16'd1;
				misc:		// halt parks the pc, other misc ops fall through
					pc_nxt = ({ir.dst, ir.imm[7:1]} == 11'h7ff) ? pc : pc + 16'd1;
				default:
					pc_nxt = pc + 16'd1;
			endcase
	end

	assign pc_next = pc_nxt[7:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags <= '0;
			covox_we <= 1'b0;
			border_we <= 1'b0;
			timer_we <= 1'b0;
			rdy <= 1'b0;
			req <= 1'b0;
			rnw <= 1'b0;
			bsel <= '0;
		end
		else
		begin
			covox_we <= port_wr && (port == port_covox);
			border_we <= port_wr && (port == port_border);
			timer_we <= port_wr && (port == port_timer_hi);
			rdy <= (ir == halt_instr);
			if (alu_wr)
			begin
				regs[ir.dst] <= alu_res;
				flags <= alu_flags;
			end
			if (port_rd)
				regs[ir.dst] <= port_in;
			if (op == djnz)
				regs[src] <= djnz_val;		// flags untouched
			if (op == o_pin)
				case (pin_idx_t'(ir.imm[4:0]))
					pin_req:	req <= ir.dst[3];
					pin_bsel0:	bsel[0] <= ir.dst[3];
					pin_bsel1:	bsel[1] <= ir.dst[3];
					pin_rnw:	rnw <= ir.dst[3];
					default:	;
				endcase
			regs[pc_hi_reg] <= pc_nxt[15:8];	// pc write wins over r14/r15
			regs[pc_lo_reg] <= pc_nxt[7:0];
		end
	end

	// port payload, qualified by the strobes above
	always_ff @(posedge clk)
	begin
		if (dram_strobe)
			dram_rdata <= dram_data_r;
		if (port_wr)
			case (port)
				port_covox:		covox <= dst_val;
				port_border:	border <= dst_val[5:0];
				port_timer_lo:	timer_lo <= dst_val;
				port_timer_hi:	timer_wdata <= {dst_val, timer_lo};
				port_addr0:		addr0 <= dst_val;
				port_addr1:		addr1 <= dst_val;
				port_addr2:		addr2 <= dst_val[4:0];
				port_wdata_lo:	wdata_lo <= dst_val;
				port_wdata_hi:	wdata_hi <= dst_val;
				default:		;
			endcase
	end

	assign dram.addr = {addr2, addr1, addr0};
	assign dram.data_w = {wdata_hi, wdata_lo};
	assign dram.req = req;
	assign dram.rnw = rnw;
	assign dram.bsel = bsel;

endmodule

`default_nettype wire

// ==== design/apu_io_pkg.sv ====
`default_nettype none

package apu_io_pkg;

	typedef logic [20:0] dram_addr_t;	// word address
	typedef logic [4:0] pin_idx_t;
	typedef logic [3:0] port_idx_t;

	// output ports
	localparam port_idx_t port_covox = 4'd0;
	localparam port_idx_t port_border = 4'd1;
	localparam port_idx_t port_timer_lo = 4'd2;
	localparam port_idx_t port_timer_hi = 4'd3;	// write here loads the timer
	localparam port_idx_t port_addr0 = 4'd4;
	localparam port_idx_t port_addr1 = 4'd5;
	localparam port_idx_t port_addr2 = 4'd6;	// only bits 4:0 kept
	localparam port_idx_t port_wdata_lo = 4'd7;
	localparam port_idx_t port_wdata_hi = 4'd8;

	// input ports
	localparam port_idx_t in_dram_lo = 4'd0;
	localparam port_idx_t in_dram_hi = 4'd1;
	localparam port_idx_t in_timer_lo = 4'd2;
	localparam port_idx_t in_timer_hi = 4'd3;
	localparam port_idx_t in_hcnt_lo = 4'd4;
	localparam port_idx_t in_hcnt_hi = 4'd5;
	localparam port_idx_t in_vcnt_lo = 4'd6;
	localparam port_idx_t in_vcnt_hi = 4'd7;

	// input pins
	localparam pin_idx_t pin_timer_end = 5'd0;
	localparam pin_idx_t pin_dram_strobe = 5'd1;
	localparam pin_idx_t pin_hsync = 5'd2;
	localparam pin_idx_t pin_hblank = 5'd3;
	localparam pin_idx_t pin_vsync = 5'd4;
	localparam pin_idx_t pin_vblank = 5'd5;

	// output pins
	localparam pin_idx_t pin_req = 5'd0;
	localparam pin_idx_t pin_bsel0 = 5'd1;
	localparam pin_idx_t pin_bsel1 = 5'd2;
	localparam pin_idx_t pin_rnw = 5'd3;

	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_t;

	typedef struct packed {
		dram_addr_t addr;
		apu_isa_pkg::word_t data_w;
		logic req;
		logic rnw;		// 1 for read
		logic [1:0] bsel;	// byte enables
	} dram_req_t;

endpackage

`default_nettype wire

// ==== design/apu_isa_pkg.sv ====
`default_nettype none

package apu_isa_pkg;

	typedef logic [7:0] byte_t;		// register and port data
	typedef logic [15:0] word_t;	// instruction or timer value
	typedef logic [7:0] code_addr_t;	// 256 words of microcode
	typedef logic [3:0] reg_idx_t;	// r0..r15

	// instruction classes, top nibble of the word
	typedef enum logic [3:0] {
		ld_imm	= 4'h0,
		and_imm	= 4'h1,
		or_imm	= 4'h2,
		xor_imm	= 4'h3,
		add_imm	= 4'h4,
		sub_imm	= 4'h5,
		wt_pin	= 4'h8,
		o_pin	= 4'h9,
		io_port	= 4'hb,
		jr		= 4'hd,
		djnz	= 4'he,
		misc	= 4'hf
	} opcode_e;

	// jr conditions, codes 9..14 are not decoded and never jump
	typedef enum logic [3:0] {
		always_c		= 4'h0,
		equal			= 4'h1,	// z
		less			= 4'h2,	// c
		nequal			= 4'h3,	// !z
		greater			= 4'h4,	// !c & !z
		lessequal		= 4'h5,	// c | z
		greaterequal	= 4'h6,	// !c
		negative		= 4'h7,	// n
		positive		= 4'h8,	// !n
		never			= 4'hf
	} cond_e;

	typedef struct packed {
		opcode_e op;
		reg_idx_t dst;		// also jump cond, pin value in bit 3
		byte_t imm;			// imm8, rel8, port or pin number
	} instr_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	localparam word_t halt_instr = 16'hffff;		// sets rdy, parks the pc
	localparam word_t halt_hold_instr = 16'hfffe;	// injected while halt is held
	localparam reg_idx_t pc_hi_reg = 4'd15;
	localparam reg_idx_t pc_lo_reg = 4'd14;

endpackage

`default_nettype wire

// ==== design/apu_timer.sv ====
`default_nettype none

module apu_timer
	import apu_isa_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire word_t wdata,
	input wire we,
	output word_t count,
	output logic cnt_end		// high while stopped at zero
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			count <= '0;
		else if (we)
			count <= wdata;		// load wins over counting
		else if (count != '0)
			count <= count - 16'd1;
	end

	assign cnt_end = (count == '0);

endmodule

`default_nettype wire

// ==== list.f ====
design/apu_isa_pkg.sv
design/apu_io_pkg.sv
design/apu_code_ram.sv
design/apu_alu.sv
design/apu_timer.sv
design/apu_core.sv
design/apu.sv
test/apu_asserts.sv
test/apu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the apu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module apu_tb -o apu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/apu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error"
	cat sim.log
	exit 1
fi

cat sim.log
if grep -q "TB PASSED" sim.log; then
	exit 0
fi
exit 1

// ==== test/apu_asserts.sv ====
`default_nettype none

module apu_asserts
(
	input wire clk,
	input wire rst_n,
	input wire halt,
	input wire rdy,
	input wire covox_we,
	input wire border_we
);

	timeunit 1ns;
	timeprecision 100ps;

	// port strobes last one cycle
	assert property (@(posedge clk) disable iff (!rst_n) covox_we |=> !covox_we)
		else $error("covox_we held longer than one cycle");

	assert property (@(posedge clk) disable iff (!rst_n) border_we |=> !border_we)
		else $error("border_we held longer than one cycle");

	// rdy is registered, so it drops one cycle after halt
	assert property (@(posedge clk) disable iff (!rst_n) $past(halt) |-> !rdy)
		else $error("rdy high while halt held");

	// quiet outputs through reset
	assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> (!covox_we && !border_we))
		else $error("strobe seen during reset");

endmodule

bind apu apu_asserts i_asserts (.*);

`default_nettype wire

// ==== test/apu_tb.sv ====
`default_nettype none

module apu_tb
	import apu_isa_pkg::*;
	import apu_io_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_tests = 5;
	localparam int timer_t = 40;		// timer load value in cycles

	logic clk, rst_n, halt, code_wen, dram_strobe;
	byte_t code_wdata;
	logic [8:0] code_waddr;
	word_t dram_data_r;
	video_t video;
	logic rdy, covox_we, border_we;
	dram_req_t dram;
	byte_t covox;
	logic [5:0] border;

	int errors = 0;
	int test_errors;
	integer seed = 92;
	byte_t covox_q[$];
	byte_t border_q[$];
	time load_time, border_time;
	logic req_d;

	apu i_apu (
		.clk(clk),
		.rst_n(rst_n),
		.halt(halt),
		.rdy(rdy),
		.code_wen(code_wen),
		.code_wdata(code_wdata),
		.code_waddr(code_waddr),
		.dram(dram),
		.dram_strobe(dram_strobe),
		.dram_data_r(dram_data_r),
		.covox(covox),
		.covox_we(covox_we),
		.border(border),
		.border_we(border_we),
		.video(video)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

	// watchdog, 5 us per test
	initial
	begin
		#(num_tests * 5000);
		$display("timeout, the tests did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	// strobe monitor
	always @(posedge clk)
	begin
		if (covox_we)
			covox_q.push_back(covox);
		if (border_we)
		begin
			border_q.push_back({2'b00, border});
			border_time = $time;
		end
		if (i_apu.timer_we)
			load_time = $time;		// timer loads on this edge
	end

	// dram model answers 4 cycles after req rises
	initial
	begin
		logic req_rise;
		dram_strobe = 1'b0;
		dram_data_r = '0;
		req_d = 1'b0;
		forever
		begin
			@(posedge clk);
			req_rise = dram.req && !req_d;
			req_d = dram.req;
			if (req_rise)
			begin
				repeat (3) @(posedge clk);
				#1;
				dram_strobe = 1'b1;
				dram_data_r = word_t'(dram.addr[15:0] * 16'd3);
				@(posedge clk);
				#1;
				dram_strobe = 1'b0;
			end
		end
	end

	function automatic word_t make_instr(opcode_e op, logic [3:0] dst, byte_t imm);
		return {op, dst, imm};
	endfunction

	function automatic word_t out_port(logic [3:0] r, port_idx_t p);
		return make_instr(io_port, r, {4'h8, p});
	endfunction

	function automatic word_t in_port(logic [3:0] r, port_idx_t p);
		return make_instr(io_port, r, {4'h0, p});
	endfunction

	function automatic word_t pin_op(opcode_e op, logic v, pin_idx_t p);
		return make_instr(op, {v, 3'b000}, {3'b000, p});
	endfunction

	task automatic check_value(string name, int expv, int actv);
		if (expv !== actv)
		begin
			$display("[ERROR] %s expected %0h actual %0h", name, expv, actv);
			test_errors++;
		end
	endtask

	task automatic check_queue(string name, byte_t expq[$], byte_t actq[$]);
		if (expq.size() != actq.size())
		begin
			$display("%s: got %0d strobes where %0d were due", name, actq.size(), expq.size());
			test_errors++;
		end
		else
			foreach (expq[i])
				check_value(name, expq[i], actq[i]);
	endtask

	task automatic load_program(word_t prog[$]);
		foreach (prog[i])
		begin
			@(posedge clk);
			#1;
			code_wen = 1'b1;
			code_waddr = 9'(i * 2);	// low byte first
			code_wdata = prog[i][7:0];
			@(posedge clk);
			#1;
			code_waddr = 9'(i * 2 + 1);
			code_wdata = prog[i][15:8];
		end
		@(posedge clk);
		#1;
		code_wen = 1'b0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!rdy && n < 2000)
		begin
			@(posedge clk);
			n++;
		end
		if (!rdy)
		begin
			$display("program never reached its halt instruction");
			test_errors++;
		end
	endtask

	task automatic run_program(word_t prog[$]);
		@(posedge clk);
		#1;
		halt = 1'b1;
		load_program(prog);
		covox_q.delete();
		border_q.delete();
		@(posedge clk);
		#1;
		halt = 1'b0;
		@(posedge clk);
		wait_ready();
	endtask

	task automatic finish_test(string name);
		if (test_errors == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errors);
		errors += test_errors;
	endtask

	task automatic test_alu_flags();
		word_t prog[$];
		byte_t expq[$];
		byte_t v[6];
		byte_t r, x, y;
		test_errors = 0;
		foreach (v[i])
			v[i] = byte_t'($random(seed));
		x = byte_t'($random(seed));
		y = byte_t'($random(seed));
		prog = {make_instr(ld_imm, 1, v[0]), out_port(1, port_covox),
			make_instr(add_imm, 1, v[1]), out_port(1, port_covox),
			make_instr(sub_imm, 1, v[2]), out_port(1, port_covox),
			make_instr(and_imm, 1, v[3]), out_port(1, port_covox),
			make_instr(or_imm, 1, v[4]), out_port(1, port_covox),
			make_instr(xor_imm, 1, v[5]), out_port(1, port_covox),
			make_instr(ld_imm, 5, 8'he1), make_instr(ld_imm, 6, 8'hc2),
			make_instr(ld_imm, 2, x), make_instr(sub_imm, 2, x),	// equal case
			make_instr(jr, nequal, 8'h02), out_port(5, port_covox),
			make_instr(ld_imm, 2, x), make_instr(sub_imm, 2, y),
			make_instr(jr, nequal, 8'h02), out_port(5, port_covox),
			make_instr(jr, greaterequal, 8'h02), out_port(6, port_covox),
			halt_instr};
		r = v[0];
		expq.push_back(r);
		r = r + v[1];
		expq.push_back(r);
		r = r - v[2];
		expq.push_back(r);
		r = r & v[3];
		expq.push_back(r);
		r = r | v[4];
		expq.push_back(r);
		r = r ^ v[5];
		expq.push_back(r);
		expq.push_back(8'he1);		// x - x is zero
		if (x == y)
			expq.push_back(8'he1);
		if (x < y)
			expq.push_back(8'hc2);	// borrow
		run_program(prog);
		check_queue("alu_flags", expq, covox_q);
		finish_test("alu_flags");
	endtask

	task automatic test_loops();
		word_t prog[$];
		byte_t expq[$];
		test_errors = 0;
		prog = {make_instr(ld_imm, 4, 8'd5), out_port(4, port_covox),
			make_instr(djnz, 4'hf, 8'hf4),	// back one to the out
			make_instr(ld_imm, 7, 8'haa), make_instr(ld_imm, 8, 8'hbb),
			make_instr(jr, never, 8'h02), out_port(7, port_covox),
			make_instr(jr, always_c, 8'h02), out_port(8, port_covox),
			halt_instr};
		expq = {8'd5, 8'd4, 8'd3, 8'd2, 8'd1, 8'haa};
		run_program(prog);
		check_queue("loops", expq, covox_q);
		finish_test("loops");
	endtask

	task automatic test_timer_wait();
		word_t prog[$];
		byte_t expq[$];
		test_errors = 0;
		prog = {make_instr(ld_imm, 9, 8'h15),
			make_instr(ld_imm, 1, byte_t'(timer_t)), out_port(1, port_timer_lo),
			make_instr(ld_imm, 1, 8'h00), out_port(1, port_timer_hi),
			make_instr(ld_imm, 3, 8'h00),	// lets the load land first
			pin_op(wt_pin, 1'b1, pin_timer_end), out_port(9, port_border),
			in_port(4, in_timer_lo), out_port(4, port_covox),
			in_port(5, in_timer_hi), out_port(5, port_covox),
			halt_instr};
		load_time = 0;
		run_program(prog);
		expq = {8'h15};
		check_queue("timer_wait border", expq, border_q);
		expq = {8'h00, 8'h00};
		check_queue("timer_wait count", expq, covox_q);
		if (load_time == 0)
		begin
			$display("timer_wait: the timer was never loaded");
			test_errors++;
		end
		else if (border_time - load_time < timer_t * 8)
		begin
			$display("timer_wait: border written %0t after load, too early",
				border_time - load_time);
			test_errors++;
		end
		finish_test("timer_wait");
	endtask

	task automatic test_dram_read();
		word_t prog[$];
		byte_t expq[$];
		byte_t a0, a1, wlo, whi;
		logic [4:0] a2;
		word_t d;
		test_errors = 0;
		a0 = byte_t'($random(seed));
		a1 = byte_t'($random(seed));
		a2 = 5'($random(seed));
		wlo = byte_t'($random(seed));
		whi = byte_t'($random(seed));
		prog = {make_instr(ld_imm, 1, a0), out_port(1, port_addr0),
			make_instr(ld_imm, 1, a1), out_port(1, port_addr1),
			make_instr(ld_imm, 1, {3'b000, a2}), out_port(1, port_addr2),
			make_instr(ld_imm, 1, wlo), out_port(1, port_wdata_lo),
			make_instr(ld_imm, 1, whi), out_port(1, port_wdata_hi),
			pin_op(o_pin, 1'b1, pin_bsel0),	// low byte lane only
			pin_op(o_pin, 1'b1, pin_rnw), pin_op(o_pin, 1'b1, pin_req),
			pin_op(wt_pin, 1'b1, pin_dram_strobe),
			in_port(2, in_dram_lo), in_port(3, in_dram_hi),
			out_port(2, port_covox), pin_op(o_pin, 1'b0, pin_req),
			out_port(3, port_covox), halt_instr};
		run_program(prog);
		d = word_t'({a1, a0} * 16'd3);
		expq = {d[7:0], d[15:8]};
		check_value("dram_read addr", {a2, a1, a0}, dram.addr);
		check_value("dram_read data_w", {whi, wlo}, dram.data_w);
		check_value("dram_read bsel", 2'b01, dram.bsel);
		check_value("dram_read rnw", 1, dram.rnw);
		check_value("dram_read req", 0, dram.req);
		check_queue("dram_read data", expq, covox_q);
		finish_test("dram_read");
	endtask

	task automatic test_halt_ready();
		word_t prog[$];
		byte_t expq[$];
		test_errors = 0;
		prog = {make_instr(ld_imm, 1, 8'h5a), out_port(1, port_covox),
			make_instr(ld_imm, 1, 8'h3c), out_port(1, port_covox), halt_instr};
		run_program(prog);
		@(posedge clk);
		check_value("halt_ready rdy", 1, rdy);	// stays up while parked
		#1;
		halt = 1'b1;
		repeat (2) @(posedge clk);
		check_value("halt_ready rdy in halt", 0, rdy);
		#1;
		halt = 1'b0;
		@(posedge clk);
		wait_ready();
		expq = {8'h5a, 8'h3c, 8'h5a, 8'h3c};	// second pass from address 0
		check_queue("halt_ready", expq, covox_q);
		finish_test("halt_ready");
	endtask

	initial
	begin
		rst_n = 1'b0;
		halt = 1'b1;
		code_wen = 1'b0;
		code_wdata = '0;
		code_waddr = '0;
		video = '0;
		load_time = 0;
		border_time = 0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_alu_flags();
		test_loops();
		test_timer_wait();
		test_dram_read();
		test_halt_ready();
		$display("tests: %0d, errors: %0d", num_tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
